// File: src.f
+incdir+include
hdl/huf_comp_pkg.sv
hdl/huf_comp_intf.sv
hdl/huf_comp_ctrl.sv
hdl/huf_comp_sc.sv
hdl/huf_comp_sq.sv
hdl/huf_comp_code_table.sv
hdl/huf_comp_sa.sv
hdl/huf_comp_core.sv
verification/huf_comp_tb.sv

// File: Makefile
TOP  = huf_comp_tb
SRCS = $(wildcard include/*.svh hdl/*.sv verification/*.sv)

.PHONY: all run check clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@$(MAKE) --no-print-directory check

check:
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: verification/huf_comp_tb.sv
// huf_comp_tb testbench with stimulus table, reference encoder model, LFSR and output monitor
`include "huf_comp_config.svh"

module huf_comp_tb;
   import huf_comp_pkg::*;

   localparam int NUM_TESTS  = 6;
   localparam int WAIT_LIMIT = 5000;
   localparam int DRIVE_DLY  = 10;

   // symbol patterns of the stimulus table
   localparam int PAT_CONST  = 0;
   localparam int PAT_MIXED  = 1;
   localparam int PAT_TIES   = 2;
   localparam int PAT_RANDOM = 3;

   logic  clk;
   logic  rst_n;
   logic  in_valid;
   sym_t  in_data;
   logic  in_last;
   logic  out_ready;
   logic  in_ready;
   logic  out_valid;
   word_t out_data;
   logic  out_last;
   logic  block_bits_valid;
   bits_t block_bits;

   // stimulus table, a bit total of -1 is left to the model alone
   string test_name [NUM_TESTS];
   int    test_len [NUM_TESTS];
   int    test_pat [NUM_TESTS];
   int    test_arg [NUM_TESTS];
   bit    test_rand_ready [NUM_TESTS];
   int    test_bits [NUM_TESTS];

   sym_t  block_syms [NUM_TESTS][`HUF_BLOCK_MAX];

   word_t exp_words [$];
   bit    exp_last [$];
   bits_t exp_bits [$];

   logic [31:0] lfsr;
   int          mismatch_count;
   int          failure_count;
   int          words_seen;
   int          out_blk;
   bit          timed_out;

   huf_comp_core huf_comp_core_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .in_valid         (in_valid),
      .in_data          (in_data),
      .in_last          (in_last),
      .out_ready        (out_ready),
      .in_ready         (in_ready),
      .out_valid        (out_valid),
      .out_data         (out_data),
      .out_last         (out_last),
      .block_bits_valid (block_bits_valid),
      .block_bits       (block_bits)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_step();
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      return lfsr[0];
   endfunction

   function automatic sym_t random_sym();
      sym_t s;
      s = '0;
      for (int b = 0; b < `HUF_SYM_WIDTH; b++) begin
         s = {s[`HUF_SYM_WIDTH-2:0], lfsr_step()};
      end
      return s;
   endfunction

   function automatic sym_t pattern_sym(input int t, input int i);
      case (test_pat[t])
         PAT_CONST: return sym_t'(test_arg[t]);
         PAT_MIXED: return sym_t'((i * 5 + i / 3) % `HUF_NUM_SYMS);
         // three symbols tie at eight each, a single 7 closes the block
         PAT_TIES:  return (i >= 24) ? sym_t'(7) : (i % 3 == 0) ? sym_t'(6) :
                           (i % 3 == 1) ? sym_t'(2) : sym_t'(4);
         default:   return random_sym();
      endcase
   endfunction

   function automatic string block_name(input int idx);
      if (idx >= 0 && idx < NUM_TESTS) begin
         return test_name[idx];
      end
      return "idle";
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
         mismatch_count++;
      end
   endtask

   task automatic note_failure(input string what);
      $display("%s", what);
      failure_count++;
   endtask

   task automatic set_test(input int idx, input string name, input int len, input int pat,
                           input int arg, input bit rand_ready, input int bits);
      test_name[idx]       = name;
      test_len[idx]        = len;
      test_pat[idx]        = pat;
      test_arg[idx]        = arg;
      test_rand_ready[idx] = rand_ready;
      test_bits[idx]       = bits;
   endtask

   task automatic load_table();
      set_test(0, "const20",  20, PAT_CONST,  5, 1'b0, 20);
      set_test(1, "mixed37",  37, PAT_MIXED,  0, 1'b0, -1);
      set_test(2, "ties25",   25, PAT_TIES,   0, 1'b1, 52);
      set_test(3, "random64", 64, PAT_RANDOM, 0, 1'b1, -1);
      set_test(4, "random10", 10, PAT_RANDOM, 0, 1'b0, -1);
      set_test(5, "single1",   1, PAT_CONST,  7, 1'b1, 1);
   endtask

   // reference encoder, ranks by count and packs the codes MSB first
   task automatic build_expected(input int t);
      int    cnt [`HUF_NUM_SYMS];
      int    rank_of [`HUF_NUM_SYMS];
      bit    taken [`HUF_NUM_SYMS];
      int    best;
      int    r;
      int    clen;
      int    total;
      int    nbits;
      word_t word;
      total = 0;
      nbits = 0;
      word  = '0;
      for (int s = 0; s < `HUF_NUM_SYMS; s++) begin
         cnt[s]   = 0;
         taken[s] = 1'b0;
      end
      for (int i = 0; i < test_len[t]; i++) begin
         cnt[block_syms[t][i]]++;
      end
      for (int k = 0; k < `HUF_NUM_SYMS; k++) begin
         best = -1;
         for (int s = 0; s < `HUF_NUM_SYMS; s++) begin
            if (!taken[s] && (best < 0 || cnt[s] > cnt[best])) begin
               best = s;
            end
         end
         taken[best]   = 1'b1;
         rank_of[best] = k;
      end
      for (int i = 0; i < test_len[t]; i++) begin
         r    = rank_of[block_syms[t][i]];
         clen = (r == `HUF_NUM_SYMS - 1) ? `HUF_MAX_CODE_LEN : r + 1;
         total += clen;
         for (int b = 0; b < clen; b++) begin
            word = {word[`HUF_WORD_WIDTH-2:0], b < r};
            nbits++;
            if (nbits == `HUF_WORD_WIDTH) begin
               exp_words.push_back(word);
               exp_last.push_back(1'b0);
               nbits = 0;
               word  = '0;
            end
         end
      end
      if (nbits > 0) begin
         exp_words.push_back(word << (`HUF_WORD_WIDTH - nbits));
         exp_last.push_back(1'b1);
      end else begin
         exp_last[exp_last.size() - 1] = 1'b1;
      end
      exp_bits.push_back(bits_t'(total));
      if (test_bits[t] >= 0) begin
         check_value({test_name[t], " model bits"}, 32'(test_bits[t]), 32'(total));
      end
   endtask

   task automatic drive_block(input int t);
      int waited;
      for (int i = 0; i < test_len[t] && !timed_out; i++) begin
         in_valid = 1'b1;
         in_data  = block_syms[t][i];
         in_last  = (i == test_len[t] - 1);
         waited   = 0;
         @(posedge clk);
         while (!in_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
         end
         if (!in_ready) begin
            note_failure({"timed out waiting for in_ready in ", test_name[t]});
            timed_out = 1'b1;
         end
         #DRIVE_DLY;
      end
      in_valid = 1'b0;
      in_last  = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_words.size() != 0 || exp_bits.size() != 0) && waited < WAIT_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_words.size() != 0 || exp_bits.size() != 0) begin
         note_failure("timed out waiting for the remaining output words");
         timed_out = 1'b1;
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatches, %0d other failures, %0d words checked",
               mismatch_count, failure_count, words_seen);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   endtask

   // sink side, about one cycle in four stalls on the back-pressure blocks
   initial begin
      out_ready = 1'b1;
      forever begin
         @(posedge clk);
         #DRIVE_DLY;
         if (out_blk < NUM_TESTS && test_rand_ready[out_blk]) begin
            out_ready = lfsr_step() | lfsr_step();
         end else begin
            out_ready = 1'b1;
         end
      end
   end

   // the input stays closed from the accepted in_last until the out_last transfer
   initial begin
      bit    closed;
      bit    reopen_due;
      bit    last_xfer;
      word_t w;
      bit    l;
      bits_t bb;
      closed     = 1'b0;
      reopen_due = 1'b0;
      forever begin
         @(posedge clk);
         if (rst_n) begin
            last_xfer = out_valid && out_ready && out_last;
            if (reopen_due) begin
               check_value({block_name(out_blk - 1), " in_ready reopen"}, 32'd1, 32'(in_ready));
               reopen_due = 1'b0;
            end
            if (closed) begin
               check_value({block_name(out_blk), " in_ready closed"}, 32'd0, 32'(in_ready));
            end
            if (in_valid && in_ready && in_last) begin
               closed = 1'b1;
            end
            if (out_valid && out_ready) begin
               if (exp_words.size() == 0) begin
                  note_failure("an output word was transferred when none was expected");
               end else begin
                  w = exp_words.pop_front();
                  l = exp_last.pop_front();
                  words_seen++;
                  check_value({block_name(out_blk), " word"}, 32'(w), 32'(out_data));
                  check_value({block_name(out_blk), " out_last"}, 32'(l), 32'(out_last));
               end
            end
            if (block_bits_valid || last_xfer) begin
               check_value({block_name(out_blk), " bits strobe"}, 32'(last_xfer),
                           32'(block_bits_valid));
            end
            if (block_bits_valid) begin
               if (exp_bits.size() == 0) begin
                  note_failure("block_bits was strobed when no block was expected");
               end else begin
                  bb = exp_bits.pop_front();
                  check_value({block_name(out_blk), " block_bits"}, 32'(bb), 32'(block_bits));
               end
            end
            if (last_xfer) begin
               out_blk++;
               closed     = 1'b0;
               reopen_due = 1'b1;
            end
         end
      end
   end

   initial begin
      rst_n          = 1'b0;
      in_valid       = 1'b0;
      in_data        = '0;
      in_last        = 1'b0;
      mismatch_count = 0;
      failure_count  = 0;
      words_seen     = 0;
      out_blk        = 0;
      timed_out      = 1'b0;
      lfsr           = 32'h502c;
      load_table();
      for (int t = 0; t < NUM_TESTS; t++) begin
         for (int i = 0; i < test_len[t]; i++) begin
            block_syms[t][i] = pattern_sym(t, i);
         end
         build_expected(t);
      end
      repeat (10) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;
      check_value("reset in_ready", 32'd1, 32'(in_ready));
      check_value("reset out_valid", 32'd0, 32'(out_valid));
      check_value("reset out_last", 32'd0, 32'(out_last));
      check_value("reset block_bits_valid", 32'd0, 32'(block_bits_valid));
      // blocks follow each other without a gap, the core holds the next one off
      for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
         drive_block(t);
      end
      if (!timed_out) begin
         wait_drain();
      end
      repeat (4) @(posedge clk);
      finish_run();
   end

endmodule

// File: hdl/huf_comp_core.sv
// huf_comp_core top level connecting controller, counters, queue, code table and assembler
module huf_comp_core (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   input  huf_comp_pkg::sym_t  in_data,
   input  logic                in_last,
   input  logic                out_ready,
   output logic                in_ready,
   output logic                out_valid,
   output huf_comp_pkg::word_t out_data,
   output logic                out_last,
   output logic                block_bits_valid,
   output huf_comp_pkg::bits_t block_bits
);
   import huf_comp_pkg::*;

   sq_if sq_bus ();

   logic       sym_inc;
   sym_t       sym;
   logic       count_clr;
   count_arr_t counts;
   logic       build_start;
   logic       build_done;
   logic       encode_start;
   logic       encode_done;
   addr_t      block_len;
   sym_t       lookup_sym;
   code_t      code;
   len_t       len;

   huf_comp_ctrl huf_comp_ctrl_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_data      (in_data),
      .in_last      (in_last),
      .build_done   (build_done),
      .encode_done  (encode_done),
      .in_ready     (in_ready),
      .sym_inc      (sym_inc),
      .sym          (sym),
      .count_clr    (count_clr),
      .build_start  (build_start),
      .encode_start (encode_start),
      .block_len    (block_len),
      .sq           (sq_bus.ctrl)
   );

   huf_comp_sc huf_comp_sc_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .sym_inc   (sym_inc),
      .sym       (sym),
      .count_clr (count_clr),
      .counts    (counts)
   );

   huf_comp_sq huf_comp_sq_i (
      .clk   (clk),
      .rst_n (rst_n),
      .q     (sq_bus.queue)
   );

   huf_comp_code_table huf_comp_code_table_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .counts      (counts),
      .build_start (build_start),
      .lookup_sym  (lookup_sym),
      .build_done  (build_done),
      .code        (code),
      .len         (len)
   );

   huf_comp_sa huf_comp_sa_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .encode_start     (encode_start),
      .block_len        (block_len),
      .code             (code),
      .len              (len),
      .out_ready        (out_ready),
      .encode_done      (encode_done),
      .lookup_sym       (lookup_sym),
      .out_valid        (out_valid),
      .out_data         (out_data),
      .out_last         (out_last),
      .block_bits_valid (block_bits_valid),
      .block_bits       (block_bits),
      .sq               (sq_bus.sa)
   );

endmodule

// File: hdl/huf_comp_sa.sv
// huf_comp_sa symbol assembler packing codes into output words and totalling block bits
`include "huf_comp_config.svh"

module huf_comp_sa (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                encode_start,
   input  huf_comp_pkg::addr_t block_len,
   input  huf_comp_pkg::code_t code,
   input  huf_comp_pkg::len_t  len,
   input  logic                out_ready,
   output logic                encode_done,
   output huf_comp_pkg::sym_t  lookup_sym,
   output logic                out_valid,
   output huf_comp_pkg::word_t out_data,
   output logic                out_last,
   output logic                block_bits_valid,
   output huf_comp_pkg::bits_t block_bits,
   sq_if.sa                    sq
);
   import huf_comp_pkg::*;

   localparam int WORD_W = `HUF_WORD_WIDTH;
   // at most 15 bits wait in the accumulator before a code is added
   localparam int ACC_W  = `HUF_WORD_WIDTH + `HUF_MAX_CODE_LEN - 1;
   localparam int FILL_W = $clog2(ACC_W + 1);

   sa_state_e         state;
   addr_t             rd_ptr;
   logic [ACC_W-1:0]  acc;
   logic [ACC_W-1:0]  acc_sum;
   logic [FILL_W-1:0] fill;
   logic [FILL_W-1:0] fill_sum;
   logic              stall;
   logic              xfer;
   logic              last_sym;
   logic              advance;
   logic              word_full;
   logic              flush_load;
   word_t             pack_word;
   word_t             flush_word;

   assign stall    = out_valid && !out_ready;
   assign xfer     = out_valid && out_ready;
   assign last_sym = (rd_ptr == block_len);
   assign advance  = (state == SA_PACK) && !stall && !last_sym;

   // the address moves only when the presented symbol is packed
   always_comb begin
      if (state == SA_IDLE) begin
         sq.rd_addr = '0;
      end else if (advance) begin
         sq.rd_addr = rd_ptr + 1'b1;
      end else begin
         sq.rd_addr = rd_ptr;
      end
   end

   assign lookup_sym = sq.rd_data;

   // codes enter at the bottom, so the oldest bit sits highest
   assign acc_sum    = (acc << len) | ACC_W'(code);
   assign fill_sum   = fill + FILL_W'(len);
   assign word_full  = (fill_sum >= FILL_W'(WORD_W));
   assign pack_word  = word_t'(acc_sum >> (fill_sum - FILL_W'(WORD_W)));
   assign flush_word = word_t'(acc << (FILL_W'(WORD_W) - fill));
   assign flush_load = (state == SA_FLUSH) && !(out_valid && out_last) && !stall;

   assign encode_done      = (state == SA_FLUSH) && xfer && out_last;
   assign block_bits_valid = encode_done;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= SA_IDLE;
         rd_ptr     <= '0;
         fill       <= '0;
         block_bits <= '0;
         out_valid  <= 1'b0;
         out_last   <= 1'b0;
      end else begin
         rd_ptr <= sq.rd_addr;
         if (xfer) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
         end
         case (state)
            SA_IDLE: begin
               if (encode_start) begin
                  fill       <= '0;
                  block_bits <= '0;
                  state      <= SA_FETCH;
               end
            end
            SA_FETCH: begin
               state <= SA_PACK;
            end
            SA_PACK: begin
               if (!stall) begin
                  block_bits <= block_bits + bits_t'(len);
                  if (word_full) begin
                     out_valid <= 1'b1;
                     fill      <= fill_sum - FILL_W'(WORD_W);
                     // an exact fit on the last symbol needs no flush word
                     out_last  <= last_sym && (fill_sum == FILL_W'(WORD_W));
                  end else begin
                     fill <= fill_sum;
                  end
                  if (last_sym) begin
                     state <= SA_FLUSH;
                  end
               end
            end
            SA_FLUSH: begin
               if (out_valid && out_last) begin
                  if (out_ready) begin
                     state <= SA_IDLE;
                  end
               end else if (!stall) begin
                  out_valid <= 1'b1;
                  out_last  <= 1'b1;
               end
            end
            default: begin
               state <= SA_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == SA_IDLE && encode_start) begin
         acc <= '0;
      end else if (state == SA_PACK && !stall) begin
         acc <= acc_sum;
         if (word_full) begin
            out_data <= pack_word;
         end
      end
      if (flush_load) begin
         out_data <= flush_word;
      end
   end

   // a stalled word stays on the bus unchanged until the sink takes it
   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

// File: hdl/huf_comp_code_table.sv
// huf_comp_code_table rank selection by frequency and rank to code/length lookup
`include "huf_comp_config.svh"

module huf_comp_code_table (
   input  logic                     clk,
   input  logic                     rst_n,
   input  huf_comp_pkg::count_arr_t counts,
   input  logic                     build_start,
   input  huf_comp_pkg::sym_t       lookup_sym,
   output logic                     build_done,
   output huf_comp_pkg::code_t      code,
   output huf_comp_pkg::len_t       len
);
   import huf_comp_pkg::*;

   localparam rank_t LAST_RANK = rank_t'(`HUF_NUM_SYMS - 1);

   rank_t                    rank_of [`HUF_NUM_SYMS];
   logic [`HUF_NUM_SYMS-1:0] ranked;
   logic [`HUF_NUM_SYMS-1:0] ranked_eff;
   rank_t                    round;
   rank_t                    round_eff;
   logic                     busy;
   logic                     active;
   sym_t                     pick;
   count_t                   pick_cnt;
   logic                     pick_found;
   rank_t                    sel_rank;
   code_t                    ones;

   // build_start is itself round zero, so the last round lands 8 cycles later
   assign active     = build_start || busy;
   assign ranked_eff = build_start ? '0 : ranked;
   assign round_eff  = build_start ? '0 : round;

   // strict compare keeps the lowest index on equal counts
   always_comb begin
      pick       = '0;
      pick_cnt   = '0;
      pick_found = 1'b0;
      for (int i = 0; i < `HUF_NUM_SYMS; i++) begin
         if (!ranked_eff[i] && (!pick_found || counts[i] > pick_cnt)) begin
            pick       = sym_t'(i);
            pick_cnt   = counts[i];
            pick_found = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         round      <= '0;
         ranked     <= '0;
         build_done <= 1'b0;
      end else begin
         build_done <= 1'b0;
         if (active) begin
            ranked       <= ranked_eff;
            ranked[pick] <= 1'b1;
            round        <= round_eff + 1'b1;
            busy         <= (round_eff != LAST_RANK);
            if (round_eff == LAST_RANK) begin
               build_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (active) begin
         rank_of[pick] <= round_eff;
      end
   end

   // rank r gets r ones and a closing zero, the last rank drops the zero
   assign sel_rank = rank_of[lookup_sym];
   assign ones     = (code_t'(1) << sel_rank) - code_t'(1);

   always_comb begin
      if (sel_rank == LAST_RANK) begin
         code = '1;
         len  = len_t'(`HUF_MAX_CODE_LEN);
      end else begin
         code = ones << 1;
         len  = len_t'(sel_rank) + 1'b1;
      end
   end

   // a new build never starts while the ranks of the previous one are still being picked
   a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      build_start |-> !busy);

endmodule

// File: hdl/huf_comp_sq.sv
// huf_comp_sq block symbol memory with one write port and a registered read port
`include "huf_comp_config.svh"

module huf_comp_sq (
   input logic  clk,
   input logic  rst_n,
   sq_if.queue  q
);
   import huf_comp_pkg::*;

   sym_t mem [`HUF_BLOCK_MAX];

   always_ff @(posedge clk) begin
      if (q.wr_en) begin
         mem[q.wr_addr] <= q.wr_data;
      end
   end

   // read every cycle, the assembler keeps only what it needs
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q.rd_data <= '0;
      end else begin
         q.rd_data <= mem[q.rd_addr];
      end
   end

endmodule

// File: hdl/huf_comp_sc.sv
// huf_comp_sc eight per-symbol frequency counters
`include "huf_comp_config.svh"

module huf_comp_sc (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     sym_inc,
   input  huf_comp_pkg::sym_t       sym,
   input  logic                     count_clr,
   output huf_comp_pkg::count_arr_t counts
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         counts <= '0;
      end else if (count_clr) begin
         counts <= '0;
      end else if (sym_inc) begin
         counts[sym] <= counts[sym] + 1'b1;
      end
   end

   // the block limit in the controller keeps every counter below its wrap point
   a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
      sym_inc |-> counts[sym] < `HUF_BLOCK_MAX);

endmodule

// File: hdl/huf_comp_ctrl.sv
// huf_comp_ctrl phase FSM with input acceptance and queue writes
`include "huf_comp_config.svh"

module huf_comp_ctrl (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   input  huf_comp_pkg::sym_t  in_data,
   input  logic                in_last,
   input  logic                build_done,
   input  logic                encode_done,
   output logic                in_ready,
   output logic                sym_inc,
   output huf_comp_pkg::sym_t  sym,
   output logic                count_clr,
   output logic                build_start,
   output logic                encode_start,
   output huf_comp_pkg::addr_t block_len,
   sq_if.ctrl                  sq
);
   import huf_comp_pkg::*;

   ctrl_state_e state;
   addr_t       wr_ptr;
   logic        accept;
   logic        block_end;

   assign in_ready = (state == ST_COUNT);
   assign accept   = in_valid && in_ready;

   // a full queue closes the block even if in_last is missing
   assign block_end = in_last || (wr_ptr == addr_t'(`HUF_BLOCK_MAX - 1));

   assign sq.wr_en   = accept;
   assign sq.wr_addr = wr_ptr;
   assign sq.wr_data = in_data;

   assign sym_inc = accept;
   assign sym     = in_data;

   assign encode_start = (state == ST_BUILD) && build_done;
   assign count_clr    = (state == ST_ENCODE) && encode_done;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= ST_COUNT;
         wr_ptr      <= '0;
         block_len   <= '0;
         build_start <= 1'b0;
      end else begin
         build_start <= 1'b0;
         case (state)
            ST_COUNT: begin
               if (accept && block_end) begin
                  // the counters take the last symbol on this edge, build starts after it
                  state       <= ST_BUILD;
                  block_len   <= wr_ptr;
                  wr_ptr      <= '0;
                  build_start <= 1'b1;
               end else if (accept) begin
                  wr_ptr <= wr_ptr + 1'b1;
               end
            end
            ST_BUILD: begin
               if (build_done) begin
                  state <= ST_ENCODE;
               end
            end
            ST_ENCODE: begin
               if (encode_done) begin
                  state <= ST_COUNT;
               end
            end
            default: begin
               state <= ST_COUNT;
            end
         endcase
      end
   end

   // build and encode completions only arrive in the phase that waits for them
   a_build_done_in_build: assert property (@(posedge clk) disable iff (!rst_n)
      build_done |-> state == ST_BUILD);
   a_encode_done_in_encode: assert property (@(posedge clk) disable iff (!rst_n)
      encode_done |-> state == ST_ENCODE);

endmodule

// File: hdl/huf_comp_intf.sv
// sq_if symbol queue interface with its ctrl, sa and queue modports
interface sq_if;
   import huf_comp_pkg::*;

   // write side, driven while a block is counted
   logic  wr_en;
   addr_t wr_addr;
   sym_t  wr_data;

   // read side, rd_data follows rd_addr by one cycle
   addr_t rd_addr;
   sym_t  rd_data;

   modport ctrl (
      output wr_en,
      output wr_addr,
      output wr_data
   );

   modport sa (
      output rd_addr,
      input  rd_data
   );

   modport queue (
      input  wr_en,
      input  wr_addr,
      input  wr_data,
      input  rd_addr,
      output rd_data
   );

endinterface

// File: hdl/huf_comp_pkg.sv
// huf_comp_pkg with the shared data types and the phase and assembler state enums
`include "huf_comp_config.svh"

package huf_comp_pkg;

   typedef logic [`HUF_SYM_WIDTH-1:0]    sym_t;
   typedef logic [`HUF_ADDR_WIDTH-1:0]   addr_t;
   typedef logic [`HUF_COUNT_WIDTH-1:0]  count_t;
   typedef count_t [`HUF_NUM_SYMS-1:0]   count_arr_t;

   // one rank per symbol, so a rank is as wide as a symbol
   typedef logic [`HUF_SYM_WIDTH-1:0]    rank_t;

   // codes are right-aligned, the upper bits above len are zero
   typedef logic [`HUF_MAX_CODE_LEN-1:0] code_t;
   typedef logic [`HUF_LEN_WIDTH-1:0]    len_t;

   typedef logic [`HUF_WORD_WIDTH-1:0]   word_t;
   typedef logic [`HUF_BITS_WIDTH-1:0]   bits_t;

   typedef enum logic [1:0] {
      ST_COUNT,
      ST_BUILD,
      ST_ENCODE
   } ctrl_state_e;

   typedef enum logic [1:0] {
      SA_IDLE,
      SA_FETCH,
      SA_PACK,
      SA_FLUSH
   } sa_state_e;

endpackage

// File: include/huf_comp_config.svh
// block encoder constants: alphabet, queue, code length and output word widths
`ifndef HUF_COMP_CONFIG_SVH
`define HUF_COMP_CONFIG_SVH

// symbol alphabet
`define HUF_SYM_WIDTH     3
`define HUF_NUM_SYMS      8

// symbol queue and frequency counters
`define HUF_BLOCK_MAX     64
`define HUF_ADDR_WIDTH    6
`define HUF_COUNT_WIDTH   7

// prefix codes
`define HUF_MAX_CODE_LEN  7
`define HUF_LEN_WIDTH     3

// output side, the bit total reaches 64 * 7 = 448
`define HUF_WORD_WIDTH    16
`define HUF_BITS_WIDTH    9

`endif
